// File: logic/rom_map_consts.svh
// ROM map constants for the download path and the read slots
// Region bounds in download byte addresses
// SDRAM offsets in 16-bit words, and bus widths

`ifndef ROM_MAP_CONSTS_SVH
`define ROM_MAP_CONSTS_SVH

// Bus widths
`define SDRAM_AW 22
`define SDRAM_DW 32
`define IOCTL_AW 25

// Download byte address bounds
`define MAIN_START 25'h00000
`define SND_START  25'h20000
`define CHAR_START 25'h28000
`define PROM_START 25'h38000
`define PROM_END   25'h38100        // Nothing stored past this

// SDRAM word offsets of each region
`define MAIN_OFFSET 22'h00000
`define SND_OFFSET  22'h10000
`define CHAR_OFFSET 22'h20000      // Relocated, not CHAR_START/2

`endif

// File: logic/rom_pkg.sv
// Shared types for the ROM read side
// SDRAM word with byte and half views
// Slot request and response structs

`default_nettype none

`include "rom_map_consts.svh"

package rom_pkg;

    // One SDRAM read word
    // Byte 0 is bits 7:0, half 0 is the even 16-bit word
    typedef union packed {
        logic [`SDRAM_DW/8-1:0][7:0]   bytes;
        logic [`SDRAM_DW/16-1:0][15:0] halves;
    } sdram_word_u;

    // Slot to arbiter
    typedef struct packed {
        logic                 req;
        logic [`SDRAM_AW-1:0] addr;    // Even SDRAM word address
    } slot_req_t;

    // Arbiter to slot
    typedef struct packed {
        logic        valid;    // One cycle, loads the slot cache
        sdram_word_u data;
    } slot_resp_t;

endpackage

`default_nettype wire

// File: logic/dl_remap.sv
// Download byte remapper
// Region decode, SDRAM word address and byte mask
// Holds each SDRAM write until acknowledged, pulses PROM writes

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module dl_remap (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    input  logic                 sdram_ack,
    output logic [`SDRAM_AW-1:0] prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we
);

    logic                 is_sdram;
    logic                 is_prom;
    logic [`IOCTL_AW-1:0] region_start;
    logic [`SDRAM_AW-1:0] region_offset;
    logic [`IOCTL_AW-1:0] rel_addr;
    logic [`SDRAM_AW-1:0] word_addr;

    always_comb begin
        is_sdram = ioctl_addr < `PROM_START;
        is_prom  = ioctl_addr >= `PROM_START && ioctl_addr < `PROM_END;
        if (ioctl_addr >= `PROM_START) begin
            region_start  = `PROM_START;
            region_offset = '0;              // PROM keeps its byte offset
        end else if (ioctl_addr >= `CHAR_START) begin
            region_start  = `CHAR_START;
            region_offset = `CHAR_OFFSET;
        end else if (ioctl_addr >= `SND_START) begin
            region_start  = `SND_START;
            region_offset = `SND_OFFSET;
        end else begin
            region_start  = `MAIN_START;
            region_offset = `MAIN_OFFSET;
        end
    end

    assign rel_addr = ioctl_addr - region_start;

    // Byte offset for the PROM, 16-bit word address for SDRAM
    assign word_addr = is_prom ? rel_addr[`SDRAM_AW-1:0]
                               : rel_addr[`SDRAM_AW:1] + region_offset;

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= ioctl_wr && is_prom;   // Single cycle strobe
            if (ioctl_wr && is_sdram) begin
                prog_we <= 1'b1;
            end else if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Write payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (ioctl_wr && (is_sdram || is_prom)) begin
            prog_addr <= word_addr;
            prog_data <= ioctl_data;
            // Active low lanes, odd bytes go high
            if (is_prom) begin
                prog_mask <= 2'b11;
            end else begin
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rom_slot.sv
// ROM read slot
// Slot address to even SDRAM word address
// One cached 32-bit word with its tag, lane select on output
// Request held until the arbiter answers

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module rom_slot #(
    parameter int                   DW     = 8,    // 8 or 16
    parameter int                   AW     = 17,
    parameter logic [`SDRAM_AW-1:0] OFFSET = '0    // SDRAM word offset
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cs,
    input  logic [AW-1:0]       addr,
    input  rom_pkg::slot_resp_t resp,
    output rom_pkg::slot_req_t  req,
    output logic [DW-1:0]       data,
    output logic                ok
);

    // Byte slots address bytes, word slots address halves
    localparam int SHIFT = (DW == 8) ? 1 : 0;

    logic [`SDRAM_AW-1:0] ext_addr;
    logic [`SDRAM_AW-1:0] scaled_addr;
    logic [`SDRAM_AW-1:0] word_addr;
    logic                 hit;
    logic                 miss_start;
    logic                 cache_valid;
    logic [`SDRAM_AW-1:0] cache_tag;
    rom_pkg::sdram_word_u cache_word;
    logic                 pending;
    logic [`SDRAM_AW-1:0] pending_addr;

    assign ext_addr    = {{(`SDRAM_AW-AW){1'b0}}, addr};
    assign scaled_addr = ext_addr >> SHIFT;
    assign word_addr   = {scaled_addr[`SDRAM_AW-1:1], 1'b0} + OFFSET;

    assign hit        = cache_valid && cache_tag == word_addr;
    assign ok         = cs && hit;
    assign miss_start = cs && !hit && !pending;

    assign req.req  = pending;
    assign req.addr = pending_addr;   // Stays fixed while pending

    generate
        if (DW == 8) begin : g_byte_lane
            assign data = cache_word.bytes[addr[1:0]];
        end else begin : g_half_lane
            assign data = cache_word.halves[addr[0]];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= 1'b0;
            cache_valid <= 1'b0;
        end else if (resp.valid) begin
            pending     <= 1'b0;
            cache_valid <= 1'b1;
        end else if (miss_start) begin
            pending <= 1'b1;
        end
    end

    // Tag comes from the fetched address, not the live one
    always_ff @(posedge clk) begin
        if (resp.valid) begin
            cache_tag  <= pending_addr;
            cache_word <= resp.data;
        end
        if (miss_start) begin
            pending_addr <= word_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/sdram_arbiter.sv
// SDRAM read arbiter for three slots
// Fixed priority main, sound, char with a registered grant
// req/ack/data_rdy sequencing and response routing

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module sdram_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  rom_pkg::slot_req_t   main_req,
    input  rom_pkg::slot_req_t   snd_req,
    input  rom_pkg::slot_req_t   char_req,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [`SDRAM_DW-1:0] data_read,
    output rom_pkg::slot_resp_t  main_resp,
    output rom_pkg::slot_resp_t  snd_resp,
    output rom_pkg::slot_resp_t  char_resp,
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic                 refresh_en
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]           state;
    logic [2:0]           grant;       // One-hot: char, snd, main
    logic [2:0]           pick;
    logic [`SDRAM_AW-1:0] pick_addr;
    logic                 start;
    logic                 done;

    always_comb begin
        pick      = 3'b000;
        pick_addr = main_req.addr;
        if (main_req.req) begin
            pick = 3'b001;
        end else if (snd_req.req) begin
            pick      = 3'b010;
            pick_addr = snd_req.addr;
        end else if (char_req.req) begin
            pick      = 3'b100;
            pick_addr = char_req.addr;
        end
    end

    assign start      = state == ST_IDLE && !downloading && pick != 3'b000;
    assign done       = state == ST_DATA && data_rdy;
    assign refresh_en = state == ST_IDLE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            grant     <= 3'b000;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    grant     <= pick;
                    sdram_req <= 1'b1;
                    state     <= ST_ACK;
                end
                ST_ACK: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= ST_DATA;
                end
                ST_DATA: if (data_rdy) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) sdram_addr <= pick_addr;   // Held through the ack wait
    end

    // Read word goes out only on the granted lane
    always_comb begin
        main_resp.valid = done && grant[0];
        main_resp.data  = data_read;
        snd_resp.valid  = done && grant[1];
        snd_resp.data   = data_read;
        char_resp.valid = done && grant[2];
        char_resp.data  = data_read;
    end

endmodule

`default_nettype wire

// File: logic/rom_loader_top.sv
// ROM loader top level
// Download remapper, three read slots and the SDRAM arbiter

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module rom_loader_top (
    input  logic                 clk,
    input  logic                 reset,
    // Download
    input  logic                 downloading,
    input  logic [`IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output logic [`SDRAM_AW-1:0] prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we,
    // SDRAM
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [`SDRAM_DW-1:0] data_read,
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic                 refresh_en,
    // Read slots
    input  logic                 main_cs,
    input  logic [16:0]          main_addr,
    output logic [7:0]           main_data,
    output logic                 main_ok,
    input  logic                 snd_cs,
    input  logic [14:0]          snd_addr,
    output logic [7:0]           snd_data,
    output logic                 snd_ok,
    input  logic                 char_cs,
    input  logic [14:0]          char_addr,
    output logic [15:0]          char_data,
    output logic                 char_ok
);

    rom_pkg::slot_req_t  main_req, snd_req, char_req;
    rom_pkg::slot_resp_t main_resp, snd_resp, char_resp;

    dl_remap u_dl_remap (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_data ( ioctl_data ),
        .ioctl_wr   ( ioctl_wr   ),
        .sdram_ack  ( sdram_ack  ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .prom_we    ( prom_we    )
    );

    rom_slot #(.DW(8), .AW(17), .OFFSET(`MAIN_OFFSET)) u_main_slot (
        .clk   ( clk       ),
        .reset ( reset     ),
        .cs    ( main_cs   ),
        .addr  ( main_addr ),
        .resp  ( main_resp ),
        .req   ( main_req  ),
        .data  ( main_data ),
        .ok    ( main_ok   )
    );

    rom_slot #(.DW(8), .AW(15), .OFFSET(`SND_OFFSET)) u_snd_slot (
        .clk   ( clk      ),
        .reset ( reset    ),
        .cs    ( snd_cs   ),
        .addr  ( snd_addr ),
        .resp  ( snd_resp ),
        .req   ( snd_req  ),
        .data  ( snd_data ),
        .ok    ( snd_ok   )
    );

    // Graphics reads 16-bit words
    rom_slot #(.DW(16), .AW(15), .OFFSET(`CHAR_OFFSET)) u_char_slot (
        .clk   ( clk       ),
        .reset ( reset     ),
        .cs    ( char_cs   ),
        .addr  ( char_addr ),
        .resp  ( char_resp ),
        .req   ( char_req  ),
        .data  ( char_data ),
        .ok    ( char_ok   )
    );

    sdram_arbiter u_arbiter (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .main_req    ( main_req    ),
        .snd_req     ( snd_req     ),
        .char_req    ( char_req    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .main_resp   ( main_resp   ),
        .snd_resp    ( snd_resp    ),
        .char_resp   ( char_resp   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .refresh_en  ( refresh_en  )
    );

endmodule

`default_nettype wire

// File: testbench/rom_loader_sva.sv
// Handshake assertions for the SDRAM arbiter and the download remapper
// Bound into both modules, inputs a module lacks are tied low

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module rom_loader_sva (
    input logic                 clk,
    input logic                 reset,
    input logic                 sdram_req,
    input logic                 sdram_ack,
    input logic [`SDRAM_AW-1:0] sdram_addr,
    input logic                 main_valid,
    input logic                 snd_valid,
    input logic                 char_valid,
    input logic                 prog_we,
    input logic                 prom_we
);

    // Request held with a fixed address until acked
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or sdram_addr moved before sdram_ack");

    a_one_valid: assert property (@(posedge clk) disable iff (reset)
        $onehot0({main_valid, snd_valid, char_valid}))
        else $error("more than one slot response valid in a cycle");

    a_we_excl: assert property (@(posedge clk) disable iff (reset)
        !(prog_we && prom_we))
        else $error("prog_we and prom_we high together");

endmodule

bind sdram_arbiter rom_loader_sva u_arbiter_sva (
    .clk        ( clk             ),
    .reset      ( reset           ),
    .sdram_req  ( sdram_req       ),
    .sdram_ack  ( sdram_ack       ),
    .sdram_addr ( sdram_addr      ),
    .main_valid ( main_resp.valid ),
    .snd_valid  ( snd_resp.valid  ),
    .char_valid ( char_resp.valid ),
    .prog_we    ( 1'b0            ),
    .prom_we    ( 1'b0            )
);

bind dl_remap rom_loader_sva u_remap_sva (
    .clk        ( clk       ),
    .reset      ( reset     ),
    .sdram_req  ( 1'b0      ),
    .sdram_ack  ( sdram_ack ),
    .sdram_addr ( '0        ),
    .main_valid ( 1'b0      ),
    .snd_valid  ( 1'b0      ),
    .char_valid ( 1'b0      ),
    .prog_we    ( prog_we   ),
    .prom_we    ( prom_we   )
);

`default_nettype wire

// File: testbench/rom_loader_tb.sv
// Testbench for the ROM loader top level
// Clock, reset and an SDRAM model with random ack and data delays
// LFSR download image, reference functions and a compare process
// Directed reads on the main, sound and char slots

`timescale 1ns/100ps
`default_nettype none

`include "rom_map_consts.svh"

module rom_loader_tb;

    localparam int SDRAM_BYTES = 144;
    localparam int PROM_BYTES  = 16;
    localparam int DL_BYTES    = SDRAM_BYTES + PROM_BYTES + 4;   // Plus bytes past the PROM
    localparam int READS       = 26;
    localparam int CYCLE_LIMIT = DL_BYTES * 8 + READS * 16 + 200;

    logic                 clk;
    logic                 reset;
    logic                 downloading;
    logic [`IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    logic [`SDRAM_AW-1:0] prog_addr;
    logic [7:0]           prog_data;
    logic [1:0]           prog_mask;
    logic                 prog_we;
    logic                 prom_we;
    logic                 sdram_ack;
    logic                 data_rdy;
    logic [`SDRAM_DW-1:0] data_read;
    logic                 sdram_req;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 refresh_en;
    logic                 main_cs;
    logic [16:0]          main_addr;
    logic [7:0]           main_data;
    logic                 main_ok;
    logic                 snd_cs;
    logic [14:0]          snd_addr;
    logic [7:0]           snd_data;
    logic                 snd_ok;
    logic                 char_cs;
    logic [14:0]          char_addr;
    logic [15:0]          char_data;
    logic                 char_ok;

    logic [15:0]          lfsr_state = 16'd96;
    logic [7:0]           dl_image [logic [`IOCTL_AW-1:0]];   // Downloaded bytes
    logic [15:0]          sdram_mem [logic [`SDRAM_AW-1:0]];
    logic [`IOCTL_AW-1:0] last_dl_addr;
    logic                 prog_we_d;
    logic                 sdram_req_d;
    logic                 read_busy;     // Open from sdram_req until data_rdy
    int                   prog_count  = 0;
    int                   prom_count  = 0;
    int                   req_count   = 0;
    int                   fail_count  = 0;
    int                   cycle_count = 0;

    rom_loader_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        fail_count = fail_count + 1;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [`IOCTL_AW-1:0] a);
        return dl_image[a];
    endfunction

    function automatic logic is_sdram_byte(input logic [`IOCTL_AW-1:0] a);
        return a < `PROM_START;
    endfunction

    function automatic logic is_prom_byte(input logic [`IOCTL_AW-1:0] a);
        return a >= `PROM_START && a < `PROM_END;
    endfunction

    // Region start and offset table applied to a download byte address
    function automatic logic [`SDRAM_AW-1:0] remap_word(input logic [`IOCTL_AW-1:0] a);
        logic [`IOCTL_AW-1:0] rel;
        logic [`SDRAM_AW-1:0] off;
        if (a >= `CHAR_START) begin
            rel = a - `CHAR_START;
            off = `CHAR_OFFSET;
        end else if (a >= `SND_START) begin
            rel = a - `SND_START;
            off = `SND_OFFSET;
        end else begin
            rel = a - `MAIN_START;
            off = `MAIN_OFFSET;
        end
        return rel[`SDRAM_AW:1] + off;
    endfunction

    function automatic logic [`SDRAM_AW-1:0] prom_offset(input logic [`IOCTL_AW-1:0] a);
        logic [`IOCTL_AW-1:0] rel;
        rel = a - `PROM_START;
        return rel[`SDRAM_AW-1:0];
    endfunction

    function automatic logic [`SDRAM_AW-1:0] main_word_addr(input logic [16:0] a);
        logic [`SDRAM_AW-1:0] w;
        w    = {6'd0, a[16:1]};
        w[0] = 1'b0;
        return w + `MAIN_OFFSET;
    endfunction

    // Little-endian pair of download bytes for a char word
    function automatic logic [15:0] char_expected(input logic [14:0] c);
        return {ref_byte(`CHAR_START + {9'd0, c, 1'b1}), ref_byte(`CHAR_START + {9'd0, c, 1'b0})};
    endfunction

    function automatic logic slot_ok(input int slot);
        if (slot == 0) return main_ok;
        if (slot == 1) return snd_ok;
        return char_ok;
    endfunction

    // SDRAM model that acks writes and reads after 1 to 4 cycles
    initial begin : sdram_model
        logic [`SDRAM_AW-1:0] a;
        logic [15:0]          word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                repeat (take_bits(2)) @(negedge clk);
                word = sdram_mem.exists(prog_addr) ? sdram_mem[prog_addr] : 16'h0000;
                if (!prog_mask[0]) word[7:0] = prog_data;
                if (!prog_mask[1]) word[15:8] = prog_data;
                sdram_mem[prog_addr] = word;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
            end else if (sdram_req) begin
                repeat (take_bits(2)) @(negedge clk);
                a = sdram_addr;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                repeat (take_bits(2)) @(negedge clk);
                data_read = {sdram_mem[{a[`SDRAM_AW-1:1], 1'b1}], sdram_mem[a]};
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

    // Compare process
    always @(posedge clk) begin
        if (reset) begin
            prog_we_d   <= 1'b0;
            sdram_req_d <= 1'b0;
            read_busy   <= 1'b0;
        end else begin
            prog_we_d   <= prog_we;
            sdram_req_d <= sdram_req;
            if (sdram_req && !sdram_req_d) req_count = req_count + 1;
            if (sdram_req) begin
                read_busy <= 1'b1;
            end else if (data_rdy) begin
                read_busy <= 1'b0;
            end
            // Refresh only while no read is open
            assert (refresh_en == !(sdram_req || read_busy))
                else report_failure($sformatf("CHECK FAILED refresh_en: got %h expected %h",
                                              refresh_en, !(sdram_req || read_busy)));
            if (prog_we && !prog_we_d) begin
                prog_count = prog_count + 1;
                assert (is_sdram_byte(last_dl_addr))
                    else report_failure("prog_we rose for a byte outside the SDRAM regions");
                assert (prog_addr == remap_word(last_dl_addr))
                    else report_failure($sformatf("CHECK FAILED prog_addr: got %h expected %h",
                                                  prog_addr, remap_word(last_dl_addr)));
                assert (prog_mask == (last_dl_addr[0] ? 2'b01 : 2'b10))
                    else report_failure($sformatf("CHECK FAILED prog_mask: got %h expected %h",
                                                  prog_mask,
                                                  last_dl_addr[0] ? 2'b01 : 2'b10));
                assert (prog_data == ref_byte(last_dl_addr))
                    else report_failure($sformatf("CHECK FAILED prog_data: got %h expected %h",
                                                  prog_data, ref_byte(last_dl_addr)));
            end
            if (prom_we) begin
                prom_count = prom_count + 1;
                assert (is_prom_byte(last_dl_addr))
                    else report_failure("prom_we pulsed for a byte outside the PROM range");
                assert (prog_addr == prom_offset(last_dl_addr))
                    else report_failure($sformatf("CHECK FAILED prog_addr: got %h expected %h",
                                                  prog_addr, prom_offset(last_dl_addr)));
                assert (prog_data == ref_byte(last_dl_addr))
                    else report_failure($sformatf("CHECK FAILED prog_data: got %h expected %h",
                                                  prog_data, ref_byte(last_dl_addr)));
            end
            if (main_ok) begin
                assert (main_data == ref_byte(`MAIN_START + {8'd0, main_addr}))
                    else report_failure($sformatf("CHECK FAILED main_data: got %h expected %h",
                                main_data, ref_byte(`MAIN_START + {8'd0, main_addr})));
            end
            if (snd_ok) begin
                assert (snd_data == ref_byte(`SND_START + {10'd0, snd_addr}))
                    else report_failure($sformatf("CHECK FAILED snd_data: got %h expected %h",
                                snd_data, ref_byte(`SND_START + {10'd0, snd_addr})));
            end
            if (char_ok) begin
                assert (char_data == char_expected(char_addr))
                    else report_failure($sformatf("CHECK FAILED char_data: got %h expected %h",
                                                  char_data, char_expected(char_addr)));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            report_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    // One byte every 8 cycles
    task automatic download_range(input logic [`IOCTL_AW-1:0] first_addr,
                                  input logic [`IOCTL_AW-1:0] last_addr);
        logic [`IOCTL_AW-1:0] a;
        for (a = first_addr; a <= last_addr; a++) begin
            @(negedge clk);
            ioctl_addr   = a;
            ioctl_data   = take_bits(8);
            dl_image[a]  = ioctl_data;
            last_dl_addr = a;
            ioctl_wr     = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            repeat (6) @(negedge clk);
        end
    endtask

    task automatic read_slot(input int slot, input logic [16:0] a);
        @(negedge clk);
        if (slot == 0) begin
            main_cs   = 1'b1;
            main_addr = a;
        end else if (slot == 1) begin
            snd_cs   = 1'b1;
            snd_addr = a[14:0];
        end else begin
            char_cs   = 1'b1;
            char_addr = a[14:0];
        end
        do @(posedge clk); while (!slot_ok(slot));
        @(negedge clk);
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        char_cs = 1'b0;
    endtask

    initial begin : stimulus
        int req_before;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        char_cs     = 1'b0;
        char_addr   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Region edges, PROM and bytes past its end
        downloading = 1'b1;
        download_range(25'h00000, 25'h0001F);
        download_range(25'h1FFF0, 25'h1FFFF);
        download_range(25'h20000, 25'h2001F);
        download_range(25'h27FF0, 25'h27FFF);
        download_range(25'h28000, 25'h2801F);
        download_range(25'h37FF0, 25'h37FFF);
        download_range(25'h38000, 25'h38007);
        download_range(25'h380F8, 25'h38103);
        repeat (4) @(negedge clk);
        downloading = 1'b0;
        assert (prog_count == SDRAM_BYTES)
            else report_failure($sformatf("saw %0d SDRAM writes instead of %0d",
                                          prog_count, SDRAM_BYTES));
        assert (prom_count == PROM_BYTES)
            else report_failure($sformatf("saw %0d PROM writes instead of %0d",
                                          prom_count, PROM_BYTES));

        for (int i = 0; i < 8; i++) read_slot(0, {9'd0, take_bits(5)});
        for (int i = 0; i < 8; i++) read_slot(1, {9'd0, take_bits(5)});
        for (int i = 0; i < 5; i++) read_slot(2, {9'd0, take_bits(4)});
        read_slot(2, 17'h07FFF);                 // Top of the relocated char region

        // Three misses at once so main goes first
        @(negedge clk);
        main_cs   = 1'b1;
        main_addr = 17'h1FFF4;
        snd_cs    = 1'b1;
        snd_addr  = 15'h7FF8;
        char_cs   = 1'b1;
        char_addr = 15'h0002;
        do @(posedge clk); while (!sdram_req);
        assert (sdram_addr == main_word_addr(17'h1FFF4))
            else report_failure($sformatf("CHECK FAILED sdram_addr: got %h expected %h",
                                          sdram_addr, main_word_addr(17'h1FFF4)));
        do @(posedge clk); while (!(main_ok && snd_ok && char_ok));
        @(negedge clk);
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        char_cs = 1'b0;

        req_before = req_count;
        read_slot(0, 17'h1FFF6);                 // Same 32-bit word as above
        assert (req_count == req_before)
            else report_failure("a read inside the cached word started a new SDRAM request");

        repeat (4) @(negedge clk);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("the run ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/rom_pkg.sv
logic/dl_remap.sv
logic/rom_slot.sv
logic/sdram_arbiter.sv
logic/rom_loader_top.sv
testbench/rom_loader_sva.sv
testbench/rom_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and search the output for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module rom_loader_tb &&
./obj_dir/Vrom_loader_tb | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
